// ==== rtl/legPkg.sv ====
// shared types for the LEGv8 subset core
// opcode patterns use ? for the don't-care bits and only work as casez items
// B.cond opcodes follow the team encoding, not the standard LEGv8 one
// no MOVZ, shifts, SLT/SLE or flag-setting logic ops
package legPkg;

  localparam int wordW = 64;
  localparam int instrW = 32;

  typedef logic [wordW-1:0] wordT;
  typedef logic [63:0] addrT;
  typedef logic [instrW-1:0] instrT;
  typedef logic [4:0] regIdxT;

  // X31 reads as zero
  localparam regIdxT zeroReg = 5'd31;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOrr,
    aluEor
  } aluOpT;

  typedef enum logic [1:0] {
    memNone,
    memLoad,
    memStore
  } memOpT;

  typedef enum logic [2:0] {
    brNone,
    brAlways,
    brEq,
    brNe,
    brLt,
    brGe,
    brCbz,
    brCbnz
  } branchT;

  // instr[31:21]
  typedef enum logic [10:0] {
    opNop  = 11'b00000000000,
    opAdd  = 11'b10001011000,
    opAddi = 11'b1001000100?,
    opAdds = 11'b10101011000,
    opSub  = 11'b11001011000,
    opSubi = 11'b1101000100?,
    opSubs = 11'b11101011000,
    opAnd  = 11'b10001010000,
    opAndi = 11'b1001001000?,
    opOrr  = 11'b10101010000,
    opOrri = 11'b1011001000?,
    opEor  = 11'b11001010000,
    opEori = 11'b1101001000?,
    opLdur = 11'b11111000010,
    opStur = 11'b11111000000,
    opB    = 11'b000101?????,
    opBeq  = 11'b01010101???,
    opBne  = 11'b01010110???,
    opBlt  = 11'b01010111???,
    opBge  = 11'b01011000???,
    opCbz  = 11'b10110100???,
    opCbnz = 11'b10110101???
  } opcodeT;

  typedef struct packed {
    logic n;
    logic z;
    logic v;
    logic c;
  } flagsT;

endpackage

// ==== rtl/idExBus.sv ====
// one decoded instruction, decode to execute
// no handshake, the bus advances every clock
// imm holds the ALU immediate or the memory offset, whichever applies
`timescale 1ns/1ps

interface idExBus import legPkg::*; ();

  logic valid;
  aluOpT aluOp;
  logic setFlags;
  logic useImm;
  wordT operandA;
  // store data for STUR
  wordT operandB;
  wordT imm;
  memOpT memOp;
  // zeroReg when nothing is written back
  regIdxT dest;

  modport producer (
    output valid, aluOp, setFlags, useImm, operandA, operandB, imm, memOp, dest
  );

  modport consumer (
    input valid, aluOp, setFlags, useImm, operandA, operandB, imm, memOp, dest
  );

endinterface

// ==== rtl/alu64.sv ====
// 64-bit ALU, carry-lookahead adder built as a binary tree of 2-input cells
// carry follows the ARM convention: set on subtract means no borrow
// carry and overflow come from the adder for every op, even logic ops
`timescale 1ns/1ps

module alu64 import legPkg::*; (
  input  wordT  a,
  input  wordT  b,
  input  aluOpT op,
  output wordT  result,
  output logic  carry,
  output logic  overflow
);

  localparam int levels = $clog2(wordW);

  logic cin;
  wordT bEff;
  wordT sum;
  // per tree level: group generate, propagate and carry-in
  logic [levels:0][wordW-1:0] gT;
  logic [levels:0][wordW-1:0] pT;
  logic [levels:0][wordW-1:0] cT;

  // subtract is a + ~b + 1
  assign cin = (op == aluSub);
  assign bEff = cin ? ~b : b;

  assign gT[0] = a & bEff;
  assign pT[0] = a ^ bEff;

  // up the tree, each node merges two children
  for (genvar lv = 1; lv <= levels; lv++) begin : gUp
    for (genvar n = 0; n < (wordW >> lv); n++) begin : gNode
      assign gT[lv][n] = gT[lv-1][2*n+1] | (pT[lv-1][2*n+1] & gT[lv-1][2*n]);
      assign pT[lv][n] = pT[lv-1][2*n+1] & pT[lv-1][2*n];
    end
  end

  // down the tree, the right child gets the carry out of the left one
  assign cT[levels][0] = cin;
  for (genvar lv = levels; lv >= 1; lv--) begin : gDown
    for (genvar n = 0; n < (wordW >> lv); n++) begin : gNode
      assign cT[lv-1][2*n] = cT[lv][n];
      assign cT[lv-1][2*n+1] = gT[lv-1][2*n] | (pT[lv-1][2*n] & cT[lv][n]);
    end
  end

  assign sum = pT[0] ^ cT[0];
  assign carry = gT[levels][0] | (pT[levels][0] & cin);
  // carry into msb differs from carry out
  assign overflow = carry ^ cT[0][wordW-1];

  // logic ops skip the adder
  always_comb begin
    case (op)
      aluAnd:  result = a & b;
      aluOrr:  result = a | b;
      aluEor:  result = a ^ b;
      default: result = sum;
    endcase
  end

endmodule

// ==== rtl/regFile.sv ====
// 31 x 64-bit registers plus the hardwired zero register X31
// writes land at the clock edge; a write in flight is bypassed to both
// read ports so a reader in the writeback cycle sees the new value
// contents are undefined until written
`timescale 1ns/1ps

module regFile import legPkg::*; (
  input  logic   clk,
  input  regIdxT rdIdxA,
  input  regIdxT rdIdxB,
  output wordT   rdDataA,
  output wordT   rdDataB,
  input  logic   wbEn,
  input  regIdxT wbIdx,
  input  wordT   wbData
);

  wordT regs [0:30];

  // writes to X31 are dropped
  always_ff @(posedge clk) begin
    if (wbEn && wbIdx != zeroReg) begin
      regs[wbIdx] <= wbData;
    end
  end

  // port A, zero reg first, then bypass
  assign rdDataA = (rdIdxA == zeroReg) ? '0 :
                   (wbEn && wbIdx == rdIdxA) ? wbData : regs[rdIdxA];

  // port B
  assign rdDataB = (rdIdxB == zeroReg) ? '0 :
                   (wbEn && wbIdx == rdIdxB) ? wbData : regs[rdIdxB];

endmodule

// ==== rtl/decodeStage.sv ====
// fetch and decode: PC, fetch/decode register, decoder, branch resolution
// branch target is branch PC + offset * 4, the next fetch is the delay slot
// conditional branches read the flags register directly, so ADDS/SUBS
// must be at least 2 instructions ahead
// unknown opcodes decode as NOP
`timescale 1ns/1ps

module decodeStage import legPkg::*; #(
  parameter addrT resetAddr = '0
) (
  input  logic   clk,
  input  logic   rstN,
  input  instrT  instr,
  output addrT   instrAddr,
  output regIdxT rdIdxA,
  output regIdxT rdIdxB,
  input  wordT   rdDataA,
  input  wordT   rdDataB,
  input  flagsT  flags,
  idExBus.producer idEx
);

  addrT   pc;
  addrT   pcNext;
  // fetch/decode register
  instrT  ifInstr;
  addrT   ifPc;
  logic   ifValid;

  logic [10:0] opField;
  regIdxT rn;
  regIdxT rm;
  regIdxT rt;
  wordT   aluImm;
  wordT   memOffset;
  addrT   brOffset;
  addrT   brTarget;

  aluOpT  aluOp;
  logic   setFlags;
  logic   useImm;
  memOpT  memOp;
  branchT branch;
  logic   writesRt;
  logic   condMet;
  logic   takeBranch;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= resetAddr;
      ifValid <= 1'b0;
    end else begin
      pc <= pcNext;
      ifValid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    ifInstr <= instr;
    ifPc <= pc;
  end

  assign instrAddr = pc;

  // instruction fields
  assign opField = ifInstr[31:21];
  assign rn = ifInstr[9:5];
  assign rm = ifInstr[20:16];
  assign rt = ifInstr[4:0];
  // 12-bit unsigned for the I forms
  assign aluImm = {{(wordW-12){1'b0}}, ifInstr[21:10]};
  // 9-bit signed for LDUR/STUR
  assign memOffset = {{(wordW-9){ifInstr[20]}}, ifInstr[20:12]};

  always_comb begin
    aluOp = aluAdd;
    setFlags = 1'b0;
    useImm = 1'b0;
    memOp = memNone;
    branch = brNone;
    writesRt = 1'b0;
    casez (opField)
      opAdd, opAddi, opAdds: writesRt = 1'b1;
      opSub, opSubi, opSubs: begin
        aluOp = aluSub;
        writesRt = 1'b1;
      end
      opAnd, opAndi: begin
        aluOp = aluAnd;
        writesRt = 1'b1;
      end
      opOrr, opOrri: begin
        aluOp = aluOrr;
        writesRt = 1'b1;
      end
      opEor, opEori: begin
        aluOp = aluEor;
        writesRt = 1'b1;
      end
      opLdur: begin
        memOp = memLoad;
        writesRt = 1'b1;
      end
      opStur: memOp = memStore;
      opB: branch = brAlways;
      opBeq: branch = brEq;
      opBne: branch = brNe;
      opBlt: branch = brLt;
      opBge: branch = brGe;
      opCbz: branch = brCbz;
      opCbnz: branch = brCbnz;
      default: ;
    endcase
    // modifier bits of the arithmetic forms
    casez (opField)
      opAddi, opSubi, opAndi, opOrri, opEori: useImm = 1'b1;
      opAdds, opSubs: setFlags = 1'b1;
      default: ;
    endcase
  end

  // CBZ/CBNZ test Rt on port A, STUR reads its data through port B
  assign rdIdxA = (branch == brCbz || branch == brCbnz) ? rt : rn;
  assign rdIdxB = (memOp == memStore) ? rt : rm;

  always_comb begin
    case (branch)
      brAlways: condMet = 1'b1;
      brEq:     condMet = flags.z;
      brNe:     condMet = !flags.z;
      brLt:     condMet = flags.n != flags.v;
      brGe:     condMet = flags.n == flags.v;
      brCbz:    condMet = rdDataA == '0;
      brCbnz:   condMet = rdDataA != '0;
      default:  condMet = 1'b0;
    endcase
  end

  // imm26 for B, imm19 for the rest
  assign brOffset = (branch == brAlways) ? {{36{ifInstr[25]}}, ifInstr[25:0], 2'b00}
                                         : {{43{ifInstr[23]}}, ifInstr[23:5], 2'b00};
  assign brTarget = ifPc + brOffset;
  assign takeBranch = ifValid && condMet;
  // delay slot at pc is already being fetched
  assign pcNext = takeBranch ? brTarget : pc + 64'd4;

  assign idEx.valid = ifValid;
  assign idEx.aluOp = aluOp;
  assign idEx.setFlags = setFlags;
  assign idEx.useImm = useImm;
  assign idEx.operandA = rdDataA;
  assign idEx.operandB = rdDataB;
  assign idEx.imm = (memOp != memNone) ? memOffset : aluImm;
  assign idEx.memOp = memOp;
  assign idEx.dest = writesRt ? rt : zeroReg;

  // a store must never reach writeback with a live destination
  assert property (@(posedge clk) disable iff (!rstN)
    idEx.valid && idEx.memOp == memStore |-> idEx.dest == zeroReg);

endmodule

// ==== rtl/executeStage.sv ====
// execute: decode/execute register, operand select, ALU, flags,
// execute/memory register
// flags only change on a valid ADDS or SUBS, at the end of execute
// memory ops always add the offset, whatever aluOp says
`timescale 1ns/1ps

module executeStage import legPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  idExBus.consumer idEx,
  output flagsT  flags,
  output memOpT  memOp,
  output wordT   aluResult,
  output wordT   storeData,
  output regIdxT dest,
  output logic   valid
);

  // decode/execute register
  logic   dxValid;
  logic   dxSetFlags;
  memOpT  dxMemOp;
  aluOpT  dxAluOp;
  logic   dxUseImm;
  wordT   dxA;
  wordT   dxB;
  wordT   dxImm;
  regIdxT dxDest;

  wordT   aluB;
  aluOpT  aluOpSel;
  wordT   result;
  logic   carry;
  logic   overflow;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      dxValid <= 1'b0;
      dxSetFlags <= 1'b0;
      dxMemOp <= memNone;
    end else begin
      dxValid <= idEx.valid;
      dxSetFlags <= idEx.setFlags;
      dxMemOp <= idEx.memOp;
    end
  end

  always_ff @(posedge clk) begin
    dxAluOp <= idEx.aluOp;
    dxUseImm <= idEx.useImm;
    dxA <= idEx.operandA;
    dxB <= idEx.operandB;
    dxImm <= idEx.imm;
    dxDest <= idEx.dest;
  end

  // imm carries the offset for loads and stores
  assign aluB = (dxUseImm || dxMemOp != memNone) ? dxImm : dxB;
  assign aluOpSel = (dxMemOp != memNone) ? aluAdd : dxAluOp;

  alu64 uAlu (
    .a(dxA), .b(aluB), .op(aluOpSel), .result(result), .carry(carry), .overflow(overflow)
  );

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (dxValid && dxSetFlags) begin
      flags.n <= result[wordW-1];
      flags.z <= result == '0;
      flags.v <= overflow;
      flags.c <= carry;
    end
  end

  // execute/memory register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      valid <= 1'b0;
      memOp <= memNone;
    end else begin
      valid <= dxValid;
      memOp <= dxMemOp;
    end
  end

  always_ff @(posedge clk) begin
    aluResult <= result;
    storeData <= dxB;
    dest <= dxDest;
  end

endmodule

// ==== rtl/memWriteback.sv ====
// memory/writeback register and writeback select
// dataRd is sampled in the memory cycle, the register file writes one edge later
// stores, branches and NOPs carry dest = X31 and never write
`timescale 1ns/1ps

module memWriteback import legPkg::*; (
  input  logic   clk,
  input  logic   rstN,
  input  logic   valid,
  input  memOpT  memOp,
  input  wordT   aluResult,
  input  regIdxT dest,
  input  wordT   dataRd,
  output logic   wbEn,
  output regIdxT wbIdx,
  output wordT   wbData
);

  logic wbValid;
  logic wbStore;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbValid <= 1'b0;
      wbStore <= 1'b0;
    end else begin
      wbValid <= valid;
      wbStore <= memOp == memStore;
    end
  end

  // load data replaces the address
  always_ff @(posedge clk) begin
    wbIdx <= dest;
    wbData <= (memOp == memLoad) ? dataRd : aluResult;
  end

  assign wbEn = wbValid && !wbStore && wbIdx != zeroReg;

  // nothing may reach the register file while reset is held
  assert property (@(posedge clk) !rstN |=> !wbEn);

endmodule

// ==== rtl/armsCore.sv ====
// five-stage LEGv8 subset core, no forwarding and no interlocks
// software must space dependent instructions: 3 apart for registers,
// 2 apart from ADDS/SUBS to a conditional branch
// branches resolve in decode with one delay slot
// dataRd must be valid combinationally in the cycle memRead is high
`timescale 1ns/1ps

module armsCore import legPkg::*; #(
  parameter addrT resetAddr = '0
) (
  input  logic  clk,
  input  logic  rstN,
  output addrT  instrAddr,
  input  instrT instr,
  output addrT  dataAddr,
  output wordT  dataWr,
  input  wordT  dataRd,
  output logic  memWrite,
  output logic  memRead
);

  regIdxT rdIdxA;
  regIdxT rdIdxB;
  wordT   rdDataA;
  wordT   rdDataB;
  flagsT  flags;
  // execute/memory register outputs
  memOpT  exMemOp;
  wordT   exAluResult;
  wordT   exStoreData;
  regIdxT exDest;
  logic   exValid;
  logic   wbEn;
  regIdxT wbIdx;
  wordT   wbData;

  idExBus idEx ();

  decodeStage #(.resetAddr(resetAddr)) uDecode (
    .clk(clk), .rstN(rstN), .instr(instr), .instrAddr(instrAddr),
    .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA), .rdDataB(rdDataB),
    .flags(flags), .idEx(idEx.producer)
  );

  regFile uRegFile (
    .clk(clk), .rdIdxA(rdIdxA), .rdIdxB(rdIdxB), .rdDataA(rdDataA), .rdDataB(rdDataB),
    .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData)
  );

  executeStage uExecute (
    .clk(clk), .rstN(rstN), .idEx(idEx.consumer), .flags(flags), .memOp(exMemOp),
    .aluResult(exAluResult), .storeData(exStoreData), .dest(exDest), .valid(exValid)
  );

  memWriteback uMemWb (
    .clk(clk), .rstN(rstN), .valid(exValid), .memOp(exMemOp), .aluResult(exAluResult),
    .dest(exDest), .dataRd(dataRd), .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData)
  );

  // memory stage strobes, one cycle per access
  assign memWrite = exValid && (exMemOp == memStore);
  assign memRead  = exValid && (exMemOp == memLoad);
  assign dataAddr = exAluResult;
  assign dataWr   = exStoreData;

endmodule

// ==== test/armsCoreTb.sv ====
// testbench for armsCore, program and expected stores built from tables
// instruction and data memories are combinational models around the DUT
// the program keeps the core's spacing rules, there is no forwarding
// DUT outputs are sampled on the falling edge
`timescale 1ns/1ps

module armsCoreTb import legPkg::*; ();

  // nonzero so the reset vector has to come through the parameter
  localparam addrT resetAddr = 64'h0000_0000_0000_0400;
  localparam int progDepth = 128;
  localparam int storeWait = 40;
  localparam int drainCycles = 20;
  localparam wordT dataPattern = 64'h5a5a_5a5a_5a5a_5a5a;
  localparam instrT nopWord = 32'h0000_0000;

  // LEGv8 opcode fields by format
  localparam logic [10:0] rAdd = 11'b10001011000;
  localparam logic [10:0] rSub = 11'b11001011000;
  localparam logic [10:0] rSubs = 11'b11101011000;
  localparam logic [10:0] rAnd = 11'b10001010000;
  localparam logic [10:0] rOrr = 11'b10101010000;
  localparam logic [10:0] rEor = 11'b11001010000;
  localparam logic [9:0] iAddi = 10'b1001000100;
  localparam logic [9:0] iSubi = 10'b1101000100;
  localparam logic [9:0] iOrri = 10'b1011001000;
  localparam logic [10:0] dLdur = 11'b11111000010;
  localparam logic [10:0] dStur = 11'b11111000000;
  // B.cond uses one opcode per condition
  localparam logic [7:0] cbBeq = 8'b01010101;
  localparam logic [7:0] cbBne = 8'b01010110;
  localparam logic [7:0] cbBlt = 8'b01010111;
  localparam logic [7:0] cbBge = 8'b01011000;
  localparam logic [7:0] cbCbz = 8'b10110100;
  localparam logic [7:0] cbCbnz = 8'b10110101;

  logic clk;
  logic rstN;
  addrT instrAddr;
  instrT instr;
  addrT dataAddr;
  wordT dataWr;
  wordT dataRd;
  logic memWrite;
  logic memRead;

  instrT progMem [0:progDepth-1];
  addrT fetchIdx;
  int progLen;
  // expected stores, in program order
  addrT expAddr [$];
  wordT expData [$];
  addrT expLoad [$];
  int loadsSeen;
  // branch PC and the fetch two cycles after it
  addrT brPc [$];
  addrT brNext [$];
  addrT fetchTrace [$];
  int seed;
  int rnd;
  // values held in X1 and X2
  wordT valA;
  wordT valB;
  // signed store offsets for the branch blocks
  int blockAddr;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // instruction memory, NOP outside the program
  assign fetchIdx = (instrAddr - resetAddr) >> 2;
  assign instr = (fetchIdx < 64'(progDepth)) ? progMem[fetchIdx[6:0]] : nopWord;
  // data memory, every address reads back its own pattern
  assign dataRd = dataAddr ^ dataPattern;

  armsCore #(.resetAddr(resetAddr)) u_dut (
    .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instr(instr),
    .dataAddr(dataAddr), .dataWr(dataWr), .dataRd(dataRd),
    .memWrite(memWrite), .memRead(memRead)
  );

  function automatic instrT encR(logic [10:0] op, int rd, int rn, int rm);
    return {op, 5'(rm), 6'b000000, 5'(rn), 5'(rd)};
  endfunction

  function automatic instrT encI(logic [9:0] op, int rd, int rn, logic [11:0] imm);
    return {op, imm, 5'(rn), 5'(rd)};
  endfunction

  function automatic instrT encD(logic [10:0] op, int rt, int rn, int off);
    return {op, 9'(off), 2'b00, 5'(rn), 5'(rt)};
  endfunction

  function automatic instrT encB(int off);
    return {6'b000101, 26'(off)};
  endfunction

  function automatic instrT encCB(logic [7:0] op, int rt, int off);
    return {op, 19'(off), 5'(rt)};
  endfunction

  // STUR Xt, [XZR, #off]
  function automatic instrT encStore(int rt, int off);
    return encD(dStur, rt, 31, off);
  endfunction

  // outcome of a B.cond after SUBS a - b, from the signed compare
  function automatic logic subsCond(logic [7:0] op, wordT a, wordT b);
    case (op)
      cbBeq: return a == b;
      cbBne: return a != b;
      cbBlt: return $signed(a) < $signed(b);
      default: return $signed(a) >= $signed(b);
    endcase
  endfunction

  task automatic failRun(string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkAddr(string name, addrT got, addrT exp);
    if (got !== exp) begin
      failRun($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkWord(string name, wordT got, wordT exp);
    if (got !== exp) begin
      failRun($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic checkBit(string name, logic got, logic exp);
    if (got !== exp) begin
      failRun($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic emit(instrT w);
    progMem[progLen[6:0]] = w;
    progLen++;
  endtask

  task automatic expectStore(int addr, wordT data);
    expAddr.push_back(64'(addr));
    expData.push_back(data);
  endtask

  // branch +3: delay slot stores X1, skipped marker stores X2
  task automatic branchBlock(instrT br, logic taken);
    addrT pc;
    pc = resetAddr + (64'(progLen) << 2);
    brPc.push_back(pc);
    if (taken) begin
      brNext.push_back(pc + 64'd12);
    end else begin
      brNext.push_back(pc + 64'd8);
    end
    emit(br);
    emit(encStore(1, blockAddr));
    expectStore(blockAddr, valA);
    emit(encStore(2, blockAddr + 8));
    if (!taken) begin
      expectStore(blockAddr + 8, valB);
    end
    blockAddr += 16;
  endtask

  task automatic condBlocks(wordT a, wordT b);
    logic [7:0] ops [$];
    ops = '{cbBeq, cbBne, cbBlt, cbBge};
    for (int i = 0; i < ops.size(); i++) begin
      branchBlock(encCB(ops[i], 0, 3), subsCond(ops[i], a, b));
    end
  endtask

  task automatic buildProgram();
    wordT aluExp [$];
    int aluReg [$];
    addrT ldA;
    addrT ldB;
    // register ALU ops and immediates, X2 ready 3 slots later
    emit(encI(iAddi, 1, 31, valA[11:0]));
    emit(encI(iAddi, 2, 31, valB[11:0]));
    emit(nopWord);
    emit(nopWord);
    emit(encR(rAdd, 3, 1, 2));
    emit(encR(rSub, 4, 1, 2));
    emit(encR(rAnd, 5, 1, 2));
    emit(encR(rOrr, 6, 1, 2));
    emit(encR(rEor, 7, 1, 2));
    emit(encI(iOrri, 8, 1, valB[11:0]));
    emit(encI(iSubi, 9, 2, valA[11:0]));
    aluReg = '{1, 3, 4, 5, 6, 7, 8, 9};
    aluExp = '{valA, valA + valB, valA - valB, valA & valB, valA | valB,
               valA ^ valB, valA | valB, valB - valA};
    for (int i = 0; i < aluReg.size(); i++) begin
      emit(encStore(aluReg[i], 8 * (i + 1)));
      expectStore(8 * (i + 1), aluExp[i]);
    end
    // loads, then the loaded registers stored back out
    ldA = 64'(-16);
    ldB = valA + 64'd24;
    emit(encD(dLdur, 10, 31, -16));
    emit(encD(dLdur, 11, 1, 24));
    emit(nopWord);
    emit(nopWord);
    emit(encStore(10, 72));
    emit(encStore(11, 80));
    expLoad.push_back(ldA);
    expLoad.push_back(ldB);
    expectStore(72, ldA ^ dataPattern);
    expectStore(80, ldB ^ dataPattern);
    // flags: equal operands, then X1 - X3 which is negative
    emit(encR(rSubs, 31, 1, 1));
    emit(nopWord);
    condBlocks(valA, valA);
    emit(encR(rSubs, 31, 1, 3));
    emit(nopWord);
    condBlocks(valA, valA + valB);
    // B always, CBZ/CBNZ on XZR and on X1/X3 (both nonzero)
    branchBlock(encB(3), 1'b1);
    branchBlock(encCB(cbCbz, 31, 3), 1'b1);
    branchBlock(encCB(cbCbnz, 3, 3), 1'b1);
    branchBlock(encCB(cbCbnz, 31, 3), 1'b0);
    branchBlock(encCB(cbCbz, 1, 3), 1'b0);
    // writes to X31 vanish
    emit(encI(iAddi, 31, 1, 12'd7));
    emit(encR(rAdd, 31, 1, 2));
    emit(nopWord);
    emit(nopWord);
    emit(encStore(31, 240));
    expectStore(240, '0);
  endtask

  // one cycle, with the fetch trace and the load checks
  task automatic stepCycle();
    @(negedge clk);
    fetchTrace.push_back(instrAddr);
    if (memRead) begin
      if (loadsSeen >= expLoad.size()) begin
        failRun("the core issued a load that the program does not contain");
      end else begin
        checkAddr("dataAddr", dataAddr, expLoad[loadsSeen]);
        loadsSeen++;
      end
    end
  endtask

  task automatic waitStore();
    int n;
    n = 0;
    stepCycle();
    while (!memWrite && n < storeWait) begin
      stepCycle();
      n++;
    end
    if (!memWrite) begin
      failRun("timed out waiting for the next store");
    end
  endtask

  // branch PC, then its delay slot, then the target or the marker
  task automatic checkBranches();
    int at;
    for (int b = 0; b < brPc.size(); b++) begin
      at = -1;
      for (int i = 0; i < fetchTrace.size(); i++) begin
        if (fetchTrace[i] == brPc[b] && at < 0) begin
          at = i;
        end
      end
      if (at < 0 || at + 2 >= fetchTrace.size()) begin
        failRun("a branch was never fetched");
      end else begin
        checkAddr("instrAddr", fetchTrace[at+1], brPc[b] + 64'd4);
        checkAddr("instrAddr", fetchTrace[at+2], brNext[b]);
      end
    end
  endtask

  initial begin
    rstN = 1'b0;
    progMem = '{default: nopWord};
    progLen = 0;
    loadsSeen = 0;
    blockAddr = -256;
    seed = 32'hd282;
    // odd values keep X1 and X3 nonzero and X1 < X3
    rnd = $random(seed);
    valA = {52'b0, rnd[11:1], 1'b1};
    rnd = $random(seed);
    valB = {52'b0, rnd[11:1], 1'b1};
    buildProgram();
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    checkAddr("instrAddr", instrAddr, resetAddr);
    checkBit("memWrite", memWrite, 1'b0);
    checkBit("memRead", memRead, 1'b0);
    for (int i = 0; i < expAddr.size(); i++) begin
      waitStore();
      checkAddr("dataAddr", dataAddr, expAddr[i]);
      checkWord("dataWr", dataWr, expData[i]);
    end
    // past the program only NOPs run
    repeat (drainCycles) begin
      stepCycle();
      if (memWrite) begin
        failRun("the core stored more than the program holds");
      end
    end
    checkBranches();
    if (loadsSeen != expLoad.size()) begin
      failRun("fewer loads than the program holds");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// ==== armsCore.f ====
rtl/legPkg.sv
rtl/idExBus.sv
rtl/alu64.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWriteback.sv
rtl/armsCore.sv
test/armsCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator and run, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module armsCoreTb -f armsCore.f \
  && ./obj_dir/VarmsCoreTb | tee /dev/stderr | grep -qxF "Done: no errors" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
